// File: all.f
common/nes_bus_pkg.sv
common/nes_video_pkg.sv
common/nes_ifs.sv
source/cpu_bus.sv
ppu/ppu_regs.sv
ppu/ppu_render.sv
ppu/ppu.sv
ppu/ppu_bus.sv
source/nes.sv
dv/tb_clk_gen.sv
dv/nes_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= nes_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/nes_tb.sv
`timescale 1ns/100ps

module nes_tb;
    import nes_bus_pkg::*;
    import nes_video_pkg::*;

    localparam int H_DOTS    = 24;
    localparam int V_LINES   = 12;
    localparam int H_VISIBLE = 16;
    localparam int V_VISIBLE = 8;

    localparam int N_RAM    = 64;
    localparam int N_CTRL   = 6;
    localparam int N_VSEQ   = 12;
    localparam int MAX_RUN  = 8;
    localparam int N_FRAMES = 8;
    localparam int N_ACCESS = N_RAM + 2 + 3 * N_CTRL + N_VSEQ * (2 * MAX_RUN + 6) + 2 * 48;
    localparam int TIMEOUT_CYCLES = (N_ACCESS * 4 + N_FRAMES * H_DOTS * V_LINES) * 2;

    logic       clk, arst_n;
    logic [1:0] cpu_phase;
    cpu_addr_t  cpu_addr;
    byte_t      cpu_wdata, cpu_rdata;
    logic       cpu_rw;
    logic       frame_trigger;
    pixel_t     pixel;
    logic       pixel_en, vblank, nmi;
    logic [2:0] ctrl_strobe;
    logic [1:0] ctrl_rd, ctrl_data;

    // Reference model state.
    byte_t      ram_m [2048];
    byte_t      nt_m [2048];
    logic       nt_ok [2048];
    byte_t      pal_m [32];
    logic       pal_ok [32];
    byte_t      ctrl_m, buf_m;
    logic       buf_ok, toggle_m;
    vram_addr_t vaddr_m;

    int         errors, checks, cycle_cnt;
    int         frame_pos; // Cycles since line 0, dot 0.
    logic       nmi_seen, vblank_exp;
    logic [1:0] rd_seen;
    pixel_t     pix_q [$];

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    nes #(
        .EXTERNAL_FRAME_TRIGGER (1),
        .H_DOTS                 (H_DOTS),
        .V_LINES                (V_LINES),
        .H_VISIBLE              (H_VISIBLE),
        .V_VISIBLE              (V_VISIBLE)
    ) u_dut (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .cpu_phase_i     (cpu_phase),
        .cpu_addr_i      (cpu_addr),
        .cpu_data_i      (cpu_wdata),
        .cpu_rw_i        (cpu_rw),
        .cpu_data_o      (cpu_rdata),
        .frame_trigger_i (frame_trigger),
        .pixel_o         (pixel),
        .pixel_en_o      (pixel_en),
        .vblank_o        (vblank),
        .nmi_o           (nmi),
        .ctrl_strobe_o   (ctrl_strobe),
        .ctrl_rd_o       (ctrl_rd),
        .ctrl_data_i     (ctrl_data)
    );

    always @(negedge clk) begin
        if (pixel_en === 1'b1) pix_q.push_back(pixel);
    end

    // Frame position, parked on the last dot until the trigger.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_pos <= 0;
        end else if (frame_pos < H_DOTS * V_LINES - 1) begin
            frame_pos <= frame_pos + 1;
        end else if (frame_trigger) begin
            frame_pos <= 0;
        end
    end

    function automatic byte_t vram_peek(input vram_addr_t a);
        if (a < NT_BASE) return 8'h00; // No pattern memory.
        if (a < PAL_BASE) return nt_m[a[10:0]];
        return pal_m[a[4:0]];
    endfunction

    function automatic logic vram_known(input vram_addr_t a);
        if (a < NT_BASE) return 1'b1;
        if (a < PAL_BASE) return nt_ok[a[10:0]];
        return pal_ok[a[4:0]];
    endfunction

    function automatic cpu_addr_t reg_addr(input reg_sel_t sel);
        return PPU_REG_START | cpu_addr_t'(($urandom % 1024) << 3) | {13'd0, sel};
    endfunction

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cpu_phase = cpu_phase + 2'd1;
    endtask

    task automatic cpu_access(input logic rw, input cpu_addr_t addr, input byte_t wdata,
                              output byte_t rdata);
        while (cpu_phase != 2'd2) next_cycle();
        cpu_rw    = rw;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        nmi_seen   = nmi;
        vblank_exp = frame_pos >= H_DOTS * V_VISIBLE;
        check_true("vblank_o differs from frame position", vblank == vblank_exp);
        next_cycle();
        rdata   = cpu_rdata;
        rd_seen = ctrl_rd;
    endtask

    task automatic reg_write(input reg_sel_t sel, input byte_t data);
        byte_t unused_q;
        cpu_access(1'b0, reg_addr(sel), data, unused_q);
        if (sel == REG_CTRL) ctrl_m = data;
        if (sel == REG_ADDR) begin
            if (!toggle_m) vaddr_m[13:8] = data[5:0];
            else vaddr_m[7:0] = data;
            toggle_m = !toggle_m;
        end
        if (sel == REG_DATA) begin
            if (vaddr_m >= PAL_BASE) begin
                pal_m[vaddr_m[4:0]]  = data;
                pal_ok[vaddr_m[4:0]] = 1'b1;
            end else begin
                nt_m[vaddr_m[10:0]]  = data;
                nt_ok[vaddr_m[10:0]] = 1'b1;
            end
            vaddr_m = vaddr_m + (ctrl_m[CTRL_INC32] ? 14'd32 : 14'd1);
        end
    endtask

    task automatic set_vaddr(input vram_addr_t a);
        reg_write(REG_ADDR, {2'b00, a[13:8]});
        reg_write(REG_ADDR, a[7:0]);
    endtask

    task automatic data_read();
        byte_t got, exp;
        logic  known;
        cpu_access(1'b1, reg_addr(REG_DATA), 8'h00, got);
        if (vaddr_m >= PAL_BASE) begin
            exp   = vram_peek(vaddr_m); // Palette bypasses the buffer.
            known = vram_known(vaddr_m);
        end else begin
            exp   = buf_m;
            known = buf_ok;
        end
        buf_m   = vram_peek(vaddr_m);
        buf_ok  = vram_known(vaddr_m);
        vaddr_m = vaddr_m + (ctrl_m[CTRL_INC32] ? 14'd32 : 14'd1);
        if (known) check_byte("$2007 read", got, exp);
    endtask

    task automatic status_read(output logic flag);
        byte_t got;
        cpu_access(1'b1, reg_addr(REG_STATUS), 8'h00, got);
        toggle_m = 1'b0;
        flag     = got[STATUS_VBLANK];
    endtask

    task automatic ram_test();
        cpu_addr_t a;
        byte_t     d, got;
        int        idx;
        int        written [$];
        for (int i = 0; i < N_RAM; i++) begin
            if (written.size() > 0 && $urandom_range(0, 1) == 1) begin
                idx = written[$urandom_range(0, written.size() - 1)];
                a   = cpu_addr_t'(idx) | (cpu_addr_t'($urandom_range(0, 3)) << 11);
                cpu_access(1'b1, a, 8'h00, got);
                check_byte("RAM read", got, ram_m[a[10:0]]);
            end else begin
                a = cpu_addr_t'($urandom_range(0, 16'h1FFF));
                d = byte_t'($urandom);
                cpu_access(1'b0, a, d, got);
                ram_m[a[10:0]] = d;
                written.push_back(int'(a[10:0]));
            end
        end
        cpu_access(1'b1, 16'h5000, 8'h00, got);
        check_byte("unmapped read", got, 8'h00);
        cpu_access(1'b1, 16'h6123, 8'h00, got);
        check_byte("unmapped read", got, 8'h00);
    endtask

    task automatic ctrl_test();
        byte_t d, got;
        logic  port;
        for (int i = 0; i < N_CTRL; i++) begin
            d = byte_t'($urandom);
            cpu_access(1'b0, CTRL1_ADDR, d, got);
            check_byte("ctrl_strobe_o", {5'd0, ctrl_strobe}, {5'd0, d[2:0]});
            port      = 1'($urandom);
            ctrl_data = 2'($urandom);
            cpu_access(1'b1, port ? CTRL2_ADDR : CTRL1_ADDR, 8'h00, got);
            check_byte("controller read", got, {7'd0, ctrl_data[port]});
            check_byte("ctrl_rd_o pulse", {6'd0, rd_seen}, port ? 8'h02 : 8'h01);
            next_cycle();
            check_byte("ctrl_rd_o after pulse", {6'd0, ctrl_rd}, 8'h00);
            check_byte("ctrl_strobe_o hold", {5'd0, ctrl_strobe}, {5'd0, d[2:0]});
        end
    endtask

    task automatic vram_test();
        vram_addr_t start;
        int         n;
        byte_t      c;
        for (int s = 0; s < N_VSEQ; s++) begin
            n = $urandom_range(1, MAX_RUN);
            c = 8'h00;
            if ($urandom_range(0, 3) == 0) begin
                start = PAL_BASE + vram_addr_t'($urandom_range(0, 31));
            end else begin
                start         = NT_BASE + vram_addr_t'($urandom_range(0, 16'h1BFF));
                c[CTRL_INC32] = 1'($urandom);
            end
            reg_write(REG_CTRL, c);
            set_vaddr(start);
            repeat (n) reg_write(REG_DATA, byte_t'($urandom));
            set_vaddr(start);
            repeat (n + 1) data_read();
        end
    endtask

    // Frame ends parked in vblank, so a fixed wait after vblank suffices.
    task automatic wait_parked();
        while (vblank !== 1'b1) next_cycle();
        repeat ((V_LINES - V_VISIBLE) * H_DOTS + 4) next_cycle();
    endtask

    task automatic load_frame();
        byte_t c;
        c              = 8'h00;
        c[CTRL_NMI_EN] = 1'b1;
        reg_write(REG_CTRL, c);
        set_vaddr(NT_BASE);
        repeat (4) reg_write(REG_DATA, byte_t'($urandom));
        set_vaddr(PAL_BASE);
        repeat (32) reg_write(REG_DATA, byte_t'($urandom));
    endtask

    task automatic run_frame(input logic bg, input logic poll);
        byte_t  m, tile;
        pixel_t exp;
        logic   flag;
        int     polls, x, y;
        m             = byte_t'($urandom);
        m[MASK_BG_EN] = bg;
        reg_write(REG_MASK, m);
        pix_q.delete();
        repeat (3 * H_DOTS) next_cycle();
        check_true("pixel_en_o seen before frame trigger", pix_q.size() == 0);
        frame_trigger = 1'b1;
        next_cycle();
        frame_trigger = 1'b0;
        check_true("vblank_o high after frame start", vblank == 1'b0);
        if (poll) begin
            flag  = 1'b0;
            polls = 0;
            while (!flag && polls < H_DOTS * V_LINES / 4 + 4) begin
                status_read(flag);
                polls++;
                check_true("status bit 7 differs from vblank", flag == vblank_exp);
                check_true("nmi_o differs from flag and enable",
                           nmi_seen == (vblank_exp && ctrl_m[CTRL_NMI_EN]));
            end
            checks++;
            assert (flag) else begin
                errors++;
                $display("Status bit 7 was never seen set while polling $2002");
            end
            status_read(flag);
            check_true("status bit 7 still set after read", flag == 1'b0);
            check_true("nmi_o still high after status read", nmi == 1'b0);
        end
        wait_parked();
        check_true("wrong pixel count in frame", pix_q.size() == H_VISIBLE * V_VISIBLE);
        for (int k = 0; k < pix_q.size(); k++) begin
            x    = k % H_VISIBLE;
            y    = k / H_VISIBLE;
            tile = nt_m[11'((y / 8) * 32 + x / 8)];
            exp  = bg ? pal_m[{1'b0, tile[3:0]}] : pal_m[5'd0];
            check_byte("pixel", pix_q[k], exp);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        cpu_phase     = 2'd0;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        cpu_rw        = 1'b1;
        frame_trigger = 1'b0;
        ctrl_data     = 2'b00;
        errors        = 0;
        checks        = 0;
        nt_ok         = '{default: 1'b0};
        pal_ok        = '{default: 1'b0};
        ctrl_m        = 8'h00;
        buf_m         = 8'h00;
        buf_ok        = 1'b0;
        toggle_m      = 1'b0;
        vaddr_m       = '0;
        void'($urandom(32'hac99));
        @(posedge arst_n);
        check_true("outputs not low after reset", pixel_en == 1'b0 && nmi == 1'b0 &&
                   vblank == 1'b0 && ctrl_rd == 2'b00 && ctrl_strobe == 3'b000);
        ram_test();
        ctrl_test();
        wait_parked();
        vram_test();
        load_frame();
        run_frame(1'b1, 1'b1);
        run_frame(1'b0, 1'b0);
        load_frame();
        run_frame(1'b1, 1'b0);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1; // Released off the edge.
    end

endmodule

// File: source/nes.sv
`timescale 1ns/100ps

module nes #(
    parameter int EXTERNAL_FRAME_TRIGGER = 1,
    parameter int H_DOTS                 = 341,
    parameter int V_LINES                = 262,
    parameter int H_VISIBLE              = 256,
    parameter int V_VISIBLE              = 240
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [1:0]             cpu_phase_i,
    input  nes_bus_pkg::cpu_addr_t cpu_addr_i,
    input  nes_bus_pkg::byte_t     cpu_data_i,
    input  logic                   cpu_rw_i,
    output nes_bus_pkg::byte_t     cpu_data_o,
    input  logic                   frame_trigger_i,
    output nes_video_pkg::pixel_t  pixel_o,
    output logic                   pixel_en_o,
    output logic                   vblank_o,
    output logic                   nmi_o,
    output logic [2:0]             ctrl_strobe_o,
    output logic [1:0]             ctrl_rd_o,
    input  logic [1:0]             ctrl_data_i
);

    cpu_reg_if u_reg_if ();
    vram_if    u_vram_if ();

    cpu_bus u_cpu_bus (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .cpu_phase_i   (cpu_phase_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_rw_i      (cpu_rw_i),
        .cpu_data_o    (cpu_data_o),
        .ctrl_strobe_o (ctrl_strobe_o),
        .ctrl_rd_o     (ctrl_rd_o),
        .ctrl_data_i   (ctrl_data_i),
        .reg_if        (u_reg_if)
    );

    ppu #(
        .EXTERNAL_FRAME_TRIGGER (EXTERNAL_FRAME_TRIGGER),
        .H_DOTS                 (H_DOTS),
        .V_LINES                (V_LINES),
        .H_VISIBLE              (H_VISIBLE),
        .V_VISIBLE              (V_VISIBLE)
    ) u_ppu (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .frame_trigger_i (frame_trigger_i),
        .pixel_o         (pixel_o),
        .pixel_en_o      (pixel_en_o),
        .vblank_o        (vblank_o),
        .nmi_o           (nmi_o),
        .reg_if          (u_reg_if),
        .vram            (u_vram_if)
    );

    ppu_bus u_ppu_bus (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .vram     (u_vram_if)
    );

endmodule

// File: ppu/ppu_bus.sv
`timescale 1ns/100ps

module ppu_bus (
    input  logic     clk_i,
    input  logic     arst_n_i,
    vram_if.mem_side vram
);
    import nes_bus_pkg::*;
    import nes_video_pkg::*;

    byte_t nt_mem  [2048];
    byte_t pal_mem [32];
    logic  nt_sel, pal_sel;

    // 0x3000-0x3EFF folds onto 0x2000 through bits 10:0.
    assign nt_sel  = vram.addr >= NT_BASE && vram.addr < PAL_BASE;
    assign pal_sel = vram.addr >= PAL_BASE; // 32 bytes mirrored to 0x3FFF.

    always_ff @(posedge clk_i) begin
        if (vram.we && nt_sel) begin
            nt_mem[vram.addr[10:0]] <= vram.wdata;
        end
        if (vram.we && pal_sel) begin
            pal_mem[vram.addr[4:0]] <= vram.wdata;
        end
        if (nt_sel) vram.rdata <= nt_mem[vram.addr[10:0]];
        else if (pal_sel) vram.rdata <= pal_mem[vram.addr[4:0]];
        else vram.rdata <= '0; // No pattern memory.
    end

    always_ff @(posedge clk_i) begin
        vram.tile <= nt_mem[vram.rd_addr[10:0]];
    end

    assign vram.pal_data = pal_mem[vram.pal_idx];

    a_no_pattern_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        vram.we |-> (nt_sel || pal_sel));

endmodule

// File: ppu/ppu.sv
`timescale 1ns/100ps

module ppu #(
    parameter int EXTERNAL_FRAME_TRIGGER = 1,
    parameter int H_DOTS                 = 341,
    parameter int V_LINES                = 262,
    parameter int H_VISIBLE              = 256,
    parameter int V_VISIBLE              = 240
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  frame_trigger_i,
    output nes_video_pkg::pixel_t pixel_o,
    output logic                  pixel_en_o,
    output logic                  vblank_o,
    output logic                  nmi_o,
    cpu_reg_if.slave              reg_if,
    vram_if.ppu_side              vram
);
    import nes_video_pkg::*;

    coord_t       dot_x_q, line_y_q;
    frame_state_t state_q;
    logic         line_end, last_dot, visible;
    logic         vblank_flag, nmi_en, bg_en;

    assign line_end = dot_x_q == coord_t'(H_DOTS - 1);
    assign last_dot = line_end && line_y_q == coord_t'(V_LINES - 1);
    assign visible  = dot_x_q < coord_t'(H_VISIBLE) && line_y_q < coord_t'(V_VISIBLE);
    assign vblank_o = line_y_q >= coord_t'(V_VISIBLE);
    assign nmi_o    = vblank_flag && nmi_en;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dot_x_q  <= '0;
            line_y_q <= '0;
            state_q  <= FRAME_RUN;
        end else begin
            case (state_q)
                FRAME_RUN: begin
                    if (last_dot && EXTERNAL_FRAME_TRIGGER != 0) begin
                        state_q <= FRAME_WAIT; // Park on the last dot.
                    end else if (line_end) begin
                        dot_x_q  <= '0;
                        line_y_q <= last_dot ? '0 : line_y_q + 1'b1;
                    end else begin
                        dot_x_q <= dot_x_q + 1'b1;
                    end
                end
                FRAME_WAIT: begin
                    if (frame_trigger_i) begin
                        dot_x_q  <= '0;
                        line_y_q <= '0;
                        state_q  <= FRAME_RUN;
                    end
                end
                default: state_q <= FRAME_RUN;
            endcase
        end
    end

    ppu_regs u_ppu_regs (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .reg_if        (reg_if),
        .vram          (vram),
        .vblank_set_i  (vblank_o),
        .vblank_flag_o (vblank_flag),
        .nmi_en_o      (nmi_en),
        .bg_en_o       (bg_en)
    );

    ppu_render u_ppu_render (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .dot_x_i    (dot_x_q),
        .line_y_i   (line_y_q),
        .visible_i  (visible),
        .bg_en_i    (bg_en),
        .vram       (vram),
        .pixel_o    (pixel_o),
        .pixel_en_o (pixel_en_o)
    );

    a_no_vblank_visible: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pixel_en_o |-> !vblank_o);

endmodule

// File: ppu/ppu_render.sv
`timescale 1ns/100ps

module ppu_render (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  nes_video_pkg::coord_t dot_x_i,
    input  nes_video_pkg::coord_t line_y_i,
    input  logic                  visible_i,
    input  logic                  bg_en_i,
    vram_if.ppu_side              vram,
    output nes_video_pkg::pixel_t pixel_o,
    output logic                  pixel_en_o
);
    import nes_video_pkg::*;

    logic vis_s1;

    // Stage 1, one name-table byte per 8x8 tile.
    assign vram.rd_addr = NT_BASE + vram_addr_t'({line_y_i[7:3], dot_x_i[7:3]});

    // Stage 2, tile arrives one cycle later.
    assign vram.pal_idx = bg_en_i ? {1'b0, vram.tile[3:0]} : 5'd0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vis_s1     <= 1'b0;
            pixel_en_o <= 1'b0;
        end else begin
            vis_s1     <= visible_i;
            pixel_en_o <= vis_s1;
        end
    end

    always_ff @(posedge clk_i) begin
        pixel_o <= vram.pal_data;
    end

endmodule

// File: ppu/ppu_regs.sv
`timescale 1ns/100ps

module ppu_regs (
    input  logic     clk_i,
    input  logic     arst_n_i,
    cpu_reg_if.slave reg_if,
    vram_if.ppu_side vram,
    input  logic     vblank_set_i,
    output logic     vblank_flag_o,
    output logic     nmi_en_o,
    output logic     bg_en_o
);
    import nes_bus_pkg::*;
    import nes_video_pkg::*;

    byte_t      ctrl_q, mask_q, buf_q;
    vram_addr_t vaddr_q, vaddr_inc;
    logic       flag_q, toggle_q, vblank_d;
    logic       rd, wr, status_rd, pal_acc;

    assign rd        = reg_if.cs && reg_if.rw;
    assign wr        = reg_if.cs && !reg_if.rw;
    assign status_rd = rd && reg_if.sel == REG_STATUS;
    assign pal_acc   = vaddr_q >= PAL_BASE;
    assign vaddr_inc = vaddr_q + (ctrl_q[CTRL_INC32] ? 14'd32 : 14'd1);

    // Memory reads vaddr every cycle, so rdata is current by the next access.
    assign vram.addr  = vaddr_q;
    assign vram.we    = wr && reg_if.sel == REG_DATA;
    assign vram.wdata = reg_if.wdata;

    assign vblank_flag_o = flag_q && vblank_set_i; // Drops with the region.
    assign nmi_en_o      = ctrl_q[CTRL_NMI_EN];
    assign bg_en_o       = mask_q[MASK_BG_EN];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q   <= '0;
            mask_q   <= '0;
            vaddr_q  <= '0;
            flag_q   <= 1'b0;
            toggle_q <= 1'b0;
            vblank_d <= 1'b0;
        end else begin
            vblank_d <= vblank_set_i;
            if (vblank_set_i && !vblank_d) flag_q <= 1'b1;
            else if (!vblank_set_i || status_rd) flag_q <= 1'b0;
            if (reg_if.cs) begin
                case (reg_if.sel)
                    REG_CTRL: if (wr) ctrl_q <= reg_if.wdata;
                    REG_MASK: if (wr) mask_q <= reg_if.wdata;
                    REG_STATUS: if (rd) toggle_q <= 1'b0;
                    REG_ADDR: begin
                        if (wr) begin
                            if (!toggle_q) vaddr_q[13:8] <= reg_if.wdata[5:0];
                            else vaddr_q[7:0] <= reg_if.wdata;
                            toggle_q <= !toggle_q;
                        end
                    end
                    REG_DATA: vaddr_q <= vaddr_inc;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            case (reg_if.sel)
                REG_STATUS: begin
                    reg_if.rdata                <= '0;
                    reg_if.rdata[STATUS_VBLANK] <= vblank_flag_o;
                end
                REG_DATA: begin
                    reg_if.rdata <= pal_acc ? vram.rdata : buf_q;
                    buf_q        <= vram.rdata; // Palette bytes land here too.
                end
                default: reg_if.rdata <= '0;
            endcase
        end
    end

endmodule

// File: source/cpu_bus.sv
`timescale 1ns/100ps

module cpu_bus (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [1:0]            cpu_phase_i,
    input  nes_bus_pkg::cpu_addr_t cpu_addr_i,
    input  nes_bus_pkg::byte_t    cpu_data_i,
    input  logic                  cpu_rw_i,
    output nes_bus_pkg::byte_t    cpu_data_o,
    output logic [2:0]            ctrl_strobe_o,
    output logic [1:0]            ctrl_rd_o,
    input  logic [1:0]            ctrl_data_i,
    cpu_reg_if.master             reg_if
);
    import nes_bus_pkg::*;

    localparam logic [1:0] SRC_NONE = 2'd0;
    localparam logic [1:0] SRC_RAM  = 2'd1;
    localparam logic [1:0] SRC_REG  = 2'd2;
    localparam logic [1:0] SRC_CTRL = 2'd3;

    byte_t      ram_mem [2**RAM_ADDR_W];
    byte_t      ram_q;
    byte_t      ctrl_q;
    logic [1:0] src_q;
    logic       acc, ram_sel, reg_sel, ctrl1_sel, ctrl2_sel;

    assign acc       = cpu_phase_i == 2'd2;
    assign ram_sel   = acc && cpu_addr_i <= RAM_END;
    assign reg_sel   = acc && cpu_addr_i >= PPU_REG_START && cpu_addr_i <= PPU_REG_END;
    assign ctrl1_sel = acc && cpu_addr_i == CTRL1_ADDR;
    assign ctrl2_sel = acc && cpu_addr_i == CTRL2_ADDR;

    // Register window mirrors every 8 bytes.
    assign reg_if.cs    = reg_sel;
    assign reg_if.rw    = cpu_rw_i;
    assign reg_if.sel   = reg_sel_t'(cpu_addr_i[2:0]);
    assign reg_if.wdata = cpu_data_i;

    always_ff @(posedge clk_i) begin
        if (ram_sel && !cpu_rw_i) begin
            ram_mem[cpu_addr_i[RAM_ADDR_W-1:0]] <= cpu_data_i;
        end
        if (ram_sel && cpu_rw_i) begin
            ram_q <= ram_mem[cpu_addr_i[RAM_ADDR_W-1:0]];
        end
        if ((ctrl1_sel || ctrl2_sel) && cpu_rw_i) begin
            ctrl_q <= {7'd0, ctrl_data_i[cpu_addr_i[0]]}; // Port 1 or 2 in bit 0.
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q         <= SRC_NONE;
            ctrl_strobe_o <= 3'd0;
            ctrl_rd_o     <= 2'd0;
        end else begin
            ctrl_rd_o <= {ctrl2_sel && cpu_rw_i, ctrl1_sel && cpu_rw_i};
            if (ctrl1_sel && !cpu_rw_i) begin
                ctrl_strobe_o <= cpu_data_i[2:0];
            end
            if (acc && cpu_rw_i) begin
                if (ram_sel) src_q <= SRC_RAM;
                else if (reg_sel) src_q <= SRC_REG;
                else if (ctrl1_sel || ctrl2_sel) src_q <= SRC_CTRL;
                else src_q <= SRC_NONE; // Unmapped reads return 0.
            end
        end
    end

    // All sources are registered, so one cycle of latency for each.
    always_comb begin
        case (src_q)
            SRC_RAM:  cpu_data_o = ram_q;
            SRC_REG:  cpu_data_o = reg_if.rdata;
            SRC_CTRL: cpu_data_o = ctrl_q;
            default:  cpu_data_o = 8'd0;
        endcase
    end

    a_ctrl_rd_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(ctrl_rd_o));

endmodule

// File: common/nes_ifs.sv
`timescale 1ns/100ps

interface cpu_reg_if;
    import nes_bus_pkg::*;

    logic     cs;    // One-cycle strobe per access.
    logic     rw;    // High for a read.
    reg_sel_t sel;
    byte_t    wdata;
    byte_t    rdata; // Valid the cycle after cs.

    modport master (output cs, rw, sel, wdata, input rdata);
    modport slave  (input cs, rw, sel, wdata, output rdata);
endinterface

interface vram_if;
    import nes_bus_pkg::*;
    import nes_video_pkg::*;

    vram_addr_t addr;
    logic       we;
    byte_t      wdata;
    byte_t      rdata;    // Registered from addr.

    vram_addr_t rd_addr;
    byte_t      tile;     // Registered from rd_addr.
    logic [4:0] pal_idx;
    pixel_t     pal_data; // Combinational from pal_idx.

    modport ppu_side (output addr, we, wdata, rd_addr, pal_idx,
                      input rdata, tile, pal_data);
    modport mem_side (input addr, we, wdata, rd_addr, pal_idx,
                      output rdata, tile, pal_data);
endinterface

// File: common/nes_video_pkg.sv
package nes_video_pkg;

    typedef logic [13:0] vram_addr_t;
    typedef logic [7:0]  pixel_t;
    typedef logic [8:0]  coord_t;

    typedef enum logic {
        FRAME_RUN,
        FRAME_WAIT
    } frame_state_t;

    // CTRL register bits.
    localparam int CTRL_NMI_EN = 7;
    localparam int CTRL_INC32  = 2;

    // MASK register bits.
    localparam int MASK_BG_EN = 3;

    // STATUS register bits.
    localparam int STATUS_VBLANK = 7;

    localparam vram_addr_t NT_BASE  = 14'h2000;
    localparam vram_addr_t PAL_BASE = 14'h3F00;

endpackage

// File: common/nes_bus_pkg.sv
package nes_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  reg_sel_t;

    // Work RAM is 2 KB, mirrored up to RAM_END.
    localparam int RAM_ADDR_W = 11;

    localparam cpu_addr_t RAM_END       = 16'h1FFF;
    localparam cpu_addr_t PPU_REG_START = 16'h2000;
    localparam cpu_addr_t PPU_REG_END   = 16'h3FFF;
    localparam cpu_addr_t CTRL1_ADDR    = 16'h4016; // Also the strobe latch.
    localparam cpu_addr_t CTRL2_ADDR    = 16'h4017;

    // Picture register offsets within the 8-byte window.
    localparam reg_sel_t REG_CTRL   = 3'd0;
    localparam reg_sel_t REG_MASK   = 3'd1;
    localparam reg_sel_t REG_STATUS = 3'd2;
    localparam reg_sel_t REG_ADDR   = 3'd6;
    localparam reg_sel_t REG_DATA   = 3'd7;

endpackage
